// File: rtl/game_pkg.sv
package game_pkg;

    // widths
    localparam int coord_w = 10;
    localparam int level_w = 3;
    localparam int color_w = 12;
    localparam int speed_w = 4;

    ////////////////////
    // palette, 4 bits per channel
    localparam logic [color_w-1:0] color_black = 12'b0000_0000_0000;
    localparam logic [color_w-1:0] color_white = 12'b1110_1010_0111;
    localparam logic [color_w-1:0] color_red   = 12'b0111_0101_0000;
    localparam logic [color_w-1:0] color_blue  = 12'b0001_1001_0110;
    localparam logic [color_w-1:0] color_cyan  = 12'b1001_1111_1010;

    // last scan position of a frame
    localparam logic [coord_w-1:0] frame_last_h = 10'd799;
    localparam logic [coord_w-1:0] frame_last_v = 10'd524;

    ////////////////////
    // play area
    localparam logic [coord_w-1:0] area_left  = 10'd250;
    localparam logic [coord_w-1:0] area_right = 10'd750;
    localparam logic [coord_w-1:0] area_top   = 10'd200;
    localparam logic [coord_w-1:0] floor_y    = 10'd350;

    // player box and motion
    localparam logic [coord_w-1:0] spawn_x  = 10'd300;
    localparam logic [coord_w-1:0] x_min    = 10'd250;
    localparam logic [coord_w-1:0] x_max    = 10'd730;
    localparam logic [coord_w-1:0] step_x   = 10'd2;
    localparam logic [coord_w-1:0] death_y  = 10'd600;
    localparam logic [coord_w-1:0] player_w = 10'd20;
    localparam logic [coord_w-1:0] player_h = 10'd30;
    localparam logic signed [speed_w-1:0] jump_speed = 4'sd5;
    localparam logic signed [speed_w-1:0] max_fall   = -4'sd6;

    // pit and door
    localparam logic [coord_w-1:0] pit_depth      = 10'd200;
    localparam logic [coord_w-1:0] door_left      = 10'd675;
    localparam logic [coord_w-1:0] door_right     = 10'd715;
    localparam logic [coord_w-1:0] door_top       = 10'd300;
    localparam logic [coord_w-1:0] door_trigger_x = 10'd670;
    localparam logic [coord_w-1:0] door_step      = 10'd5;
    localparam logic [coord_w-1:0] door_full      = 10'd50;
    localparam logic [coord_w-1:0] blackout_ticks = 10'd50;

    ////////////////////
    // levels
    localparam logic [level_w-1:0] level_start = 3'd0;
    localparam logic [level_w-1:0] level_last  = 3'd4;
    localparam logic [coord_w-1:0] pit_guard_lo = 10'd5;
    localparam logic [coord_w-1:0] pit_guard_hi = 10'd12;

    function automatic logic [coord_w-1:0] pit_visual_start(input logic [level_w-1:0] lvl);
        case (lvl)
            3'd1: pit_visual_start = 10'd500;
            3'd2: pit_visual_start = 10'd450;
            3'd3: pit_visual_start = 10'd600;
            3'd4: pit_visual_start = 10'd500;
            default: pit_visual_start = '0;
        endcase
    endfunction

    function automatic logic [coord_w-1:0] pit_visual_end(input logic [level_w-1:0] lvl);
        case (lvl)
            3'd1: pit_visual_end = 10'd550;
            3'd2: pit_visual_end = 10'd500;
            3'd3: pit_visual_end = 10'd650;
            3'd4: pit_visual_end = 10'd550;
            default: pit_visual_end = '0;
        endcase
    endfunction

    // hit span sits a little inside the painted pit
    function automatic logic over_pit(input logic [level_w-1:0] lvl,
                                      input logic [coord_w-1:0] x);
        int lo;
        int hi;
        lo = int'(pit_visual_start(lvl)) - int'(pit_guard_lo);
        hi = int'(pit_visual_end(lvl)) - int'(pit_guard_hi);
        over_pit = (int'(x) > lo) && (int'(x) < hi);
    endfunction

endpackage

// File: rtl/input_sync.sv
`timescale 1ns/1ps

module input_sync import game_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               up,
    input  logic               left,
    input  logic               right,
    input  logic [coord_w-1:0] h_count,
    input  logic [coord_w-1:0] v_count,
    output logic               up_s,
    output logic               left_s,
    output logic               right_s,
    output logic               tick,
    output logic               slow_tick
);

    logic [2:0] btn_meta;
    logic [1:0] phase;
    logic       frame_end;

    assign frame_end = (h_count == frame_last_h) && (v_count == frame_last_v);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            btn_meta  <= '0;
            {up_s, left_s, right_s} <= '0;
            tick      <= 1'b0;
            slow_tick <= 1'b0;
            phase     <= '0;
        end else begin
            btn_meta  <= {up, left, right};
            {up_s, left_s, right_s} <= btn_meta;
            tick      <= frame_end;
            // every third frame
            slow_tick <= frame_end && (phase == 2'd2);
            if (frame_end) begin
                phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
            end
        end
    end

endmodule

// File: rtl/player_motion.sv
`timescale 1ns/1ps

module player_motion import game_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               tick,
    input  logic               slow_tick,
    input  logic               up_s,
    input  logic               left_s,
    input  logic               right_s,
    input  logic [level_w-1:0] level,
    input  logic [coord_w-1:0] door_count,
    input  logic               respawn,
    output logic [coord_w-1:0] player_x,
    output logic [coord_w-1:0] player_y
);

    logic signed [speed_w-1:0] speed;
    logic                      airborne;

    logic [coord_w-1:0]        nx;
    logic [coord_w-1:0]        ny;
    logic signed [speed_w-1:0] nspeed;
    logic                      nair;

    // positive speed moves the player up the screen
    function automatic logic [coord_w-1:0] y_minus(input logic [coord_w-1:0] y,
                                                   input logic signed [speed_w-1:0] s);
        logic signed [coord_w+1:0] r;
        r = $signed({2'b00, y}) - $signed({{(coord_w+2-speed_w){s[speed_w-1]}}, s});
        y_minus = r[coord_w-1:0];
    endfunction

    ////////////////////
    // next state, one step per frame
    always_comb begin
        nx     = player_x;
        ny     = player_y;
        nspeed = speed;
        nair   = airborne;
        if (respawn) begin
            nx     = spawn_x;
            ny     = floor_y;
            nspeed = '0;
            nair   = 1'b0;
        end else begin
            // no walking once sunk into a pit or while the door shuts
            if ((door_count == '0) && (player_y <= floor_y) && (left_s ^ right_s)) begin
                if (right_s) begin
                    if (player_x < x_max) begin
                        nx = player_x + step_x;
                    end
                end else if (player_x > x_min) begin
                    nx = player_x - step_x;
                end
            end

            if (up_s && !airborne) begin
                ny     = y_minus(player_y, jump_speed);
                nspeed = jump_speed;
                nair   = 1'b1;
            end else if (airborne) begin
                ny = y_minus(player_y, speed);
                // gravity
                if (slow_tick && (speed != max_fall)) begin
                    nspeed = speed - speed_w'(1);
                end
                if ((ny >= floor_y) && !over_pit(level, nx)) begin
                    ny     = floor_y;
                    nspeed = '0;
                    nair   = 1'b0;
                end
            end else if (over_pit(level, nx)) begin
                // walked off the edge
                nspeed = '0;
                nair   = 1'b1;
            end

            if (ny >= death_y) begin
                nx     = spawn_x;
                ny     = floor_y;
                nspeed = '0;
                nair   = 1'b0;
            end
        end
    end

    ////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            player_x <= spawn_x;
            player_y <= floor_y;
            speed    <= '0;
            airborne <= 1'b0;
        end else if (tick) begin
            player_x <= nx;
            player_y <= ny;
            speed    <= nspeed;
            airborne <= nair;
        end
    end

endmodule

// File: rtl/level_sequencer.sv
`timescale 1ns/1ps

module level_sequencer import game_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               tick,
    input  logic               slow_tick,
    input  logic [coord_w-1:0] player_x,
    output logic [level_w-1:0] level,
    output logic [coord_w-1:0] door_count,
    output logic               blackout,
    output logic               respawn
);

    logic [coord_w-1:0] blackout_timer;
    logic               timer_done;
    logic               on_start;

    // screen stays dark while the door is fully shut
    assign blackout   = (door_count == door_full);
    assign timer_done = (blackout_timer == blackout_ticks - coord_w'(1));
    assign on_start   = (level == level_start);

    // new level or leaving the start screen puts the player back at spawn
    assign respawn = tick && (on_start || (blackout && timer_done));

    ////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            level          <= level_start;
            door_count     <= '0;
            blackout_timer <= '0;
        end else if (tick) begin
            if (on_start) begin
                level          <= level_start + level_w'(1);
                door_count     <= '0;
                blackout_timer <= '0;
            end else if (blackout) begin
                if (timer_done) begin
                    // after the last level back to the start screen
                    if (level == level_last) begin
                        level <= level_start;
                    end else begin
                        level <= level + level_w'(1);
                    end
                    door_count     <= '0;
                    blackout_timer <= '0;
                end else begin
                    blackout_timer <= blackout_timer + coord_w'(1);
                end
            end else if ((player_x > door_trigger_x) && slow_tick) begin
                // door slides down a few lines at a time
                door_count <= door_count + door_step;
            end
        end
    end

endmodule

// File: rtl/pixel_painter.sv
`timescale 1ns/1ps

module pixel_painter import game_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [coord_w-1:0] h_count,
    input  logic [coord_w-1:0] v_count,
    input  logic [level_w-1:0] level,
    input  logic [coord_w-1:0] door_count,
    input  logic               blackout,
    input  logic [coord_w-1:0] player_x,
    input  logic [coord_w-1:0] player_y,
    output logic [color_w-1:0] rgb
);

    logic               in_player;
    logic               in_door;
    logic               in_pit;
    logic               in_area;
    logic [color_w-1:0] color_next;

    // box hangs up from the feet at player_y
    assign in_player = (h_count >= player_x) && (h_count <= player_x + player_w - coord_w'(1))
                    && (v_count <= player_y) && (v_count + player_h - coord_w'(1) >= player_y);

    assign in_door = (h_count >= door_left) && (h_count <= door_right)
                  && (v_count >= door_top + door_count) && (v_count <= floor_y);

    assign in_pit = (h_count >= pit_visual_start(level)) && (h_count <= pit_visual_end(level))
                 && (v_count > floor_y) && (v_count <= floor_y + pit_depth);

    assign in_area = (h_count >= area_left) && (h_count <= area_right)
                  && (v_count >= area_top) && (v_count <= floor_y);

    ////////////////////
    // priority, highest first
    always_comb begin
        if (level == level_start) begin
            color_next = color_black;
        end else if (in_player) begin
            color_next = color_black;
        end else if (blackout) begin
            color_next = color_black;
        end else if (in_door) begin
            color_next = color_cyan;
        end else if (in_pit) begin
            color_next = color_blue;
        end else if (in_area) begin
            color_next = color_white;
        end else begin
            color_next = color_red;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rgb <= color_black;
        end else begin
            rgb <= color_next;
        end
    end

endmodule

// File: rtl/platform_game_top.sv
`timescale 1ns/1ps

module platform_game_top import game_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               up,
    input  logic               left,
    input  logic               right,
    input  logic [coord_w-1:0] h_count,
    input  logic [coord_w-1:0] v_count,
    output logic [color_w-1:0] rgb,
    output logic [level_w-1:0] level
);

    logic               up_s;
    logic               left_s;
    logic               right_s;
    logic               tick;
    logic               slow_tick;
    logic [coord_w-1:0] door_count;
    logic               blackout;
    logic               respawn;
    logic [coord_w-1:0] player_x;
    logic [coord_w-1:0] player_y;

    ////////////////////
    // buttons and frame timing
    input_sync input_sync_i (
        .clk       (clk),
        .reset     (reset),
        .up        (up),
        .left      (left),
        .right     (right),
        .h_count   (h_count),
        .v_count   (v_count),
        .up_s      (up_s),
        .left_s    (left_s),
        .right_s   (right_s),
        .tick      (tick),
        .slow_tick (slow_tick)
    );

    player_motion player_motion_i (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .slow_tick  (slow_tick),
        .up_s       (up_s),
        .left_s     (left_s),
        .right_s    (right_s),
        .level      (level),
        .door_count (door_count),
        .respawn    (respawn),
        .player_x   (player_x),
        .player_y   (player_y)
    );

    level_sequencer level_sequencer_i (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .slow_tick  (slow_tick),
        .player_x   (player_x),
        .level      (level),
        .door_count (door_count),
        .blackout   (blackout),
        .respawn    (respawn)
    );

    ////////////////////
    // pixel colour out
    pixel_painter pixel_painter_i (
        .clk        (clk),
        .reset      (reset),
        .h_count    (h_count),
        .v_count    (v_count),
        .level      (level),
        .door_count (door_count),
        .blackout   (blackout),
        .player_x   (player_x),
        .player_y   (player_y),
        .rgb        (rgb)
    );

endmodule

// File: tests/platform_game_sva.sv
`timescale 1ns/1ps

module level_sequencer_sva import game_pkg::*; (
    input logic               clk,
    input logic               reset,
    input logic [level_w-1:0] level,
    input logic [coord_w-1:0] door_count,
    input logic               respawn
);

    level_in_range: assert property (@(posedge clk) disable iff (reset) level <= level_last)
        else $error("level %0d beyond the last level", level);

    // a respawn from here always comes with a new level
    respawn_on_level_change: assert property (@(posedge clk) disable iff (reset)
        respawn |=> (level != $past(level)))
        else $error("respawn without a level change");

    door_in_range: assert property (@(posedge clk) disable iff (reset) door_count <= door_full)
        else $error("door count %0d past fully shut", door_count);

endmodule

bind level_sequencer level_sequencer_sva level_sequencer_sva_i (
    .clk        (clk),
    .reset      (reset),
    .level      (level),
    .door_count (door_count),
    .respawn    (respawn)
);

// File: tests/platform_game_tb.sv
`timescale 1ns/1ps

module platform_game_tb import game_pkg::*; ();

    // ticks of all tests, each with its button setup and up to five probes
    localparam int tick_budget     = 1 + 120 + 60 + 250 + 4 * 320;
    localparam int cycles_per_tick = 6 + 2 * 5;
    localparam int max_cycles      = tick_budget * cycles_per_tick + 1000;

    logic               clk;
    logic               reset;
    logic               up;
    logic               left;
    logic               right;
    logic [coord_w-1:0] h_count;
    logic [coord_w-1:0] v_count;
    logic [color_w-1:0] rgb;
    logic [level_w-1:0] level;

    // reference model state
    int m_x;
    int m_y;
    int m_speed;
    bit m_air;
    int m_level;
    int m_door;
    int m_timer;
    int m_ticks;
    bit m_died;

    // one pending check at a time
    string              cur_test;
    string              chk_label;
    bit                 chk_is_level;
    logic [color_w-1:0] chk_exp_color;
    logic [level_w-1:0] chk_exp_level;
    int                 chk_req;
    int                 chk_done;

    int         errors;
    int         faults;
    int         errors_at_start;
    int         tests_run;
    int         cycles;
    logic [7:0] lfsr;

    platform_game_top platform_game_top_i (
        .clk     (clk),
        .reset   (reset),
        .up      (up),
        .left    (left),
        .right   (right),
        .h_count (h_count),
        .v_count (v_count),
        .rgb     (rgb),
        .level   (level)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a test never finished", cycles);
        $display("** FAIL **");
        $finish;
    end

    ////////////////////
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic int pit_start_of(input int lvl);
        case (lvl)
            1: return 500;
            2: return 450;
            3: return 600;
            4: return 500;
            default: return 0;
        endcase
    endfunction

    // hit span, narrower than the painted pit
    function automatic bit in_pit_span(input int x);
        int ps;
        ps = pit_start_of(m_level);
        if (m_level == 0) begin
            return 1'b0;
        end
        return (x > ps - int'(pit_guard_lo)) && (x < ps + 50 - int'(pit_guard_hi));
    endfunction

    function automatic logic [color_w-1:0] expected_color(input int h, input int v);
        int ps;
        ps = pit_start_of(m_level);
        if (m_level == int'(level_start)) begin
            return color_black;
        end
        if (h >= m_x && h <= m_x + int'(player_w) - 1
            && v >= m_y - int'(player_h) + 1 && v <= m_y) begin
            return color_black;
        end
        if (m_door == int'(door_full)) begin
            return color_black;
        end
        if (h >= 675 && h <= 715 && v >= 300 + m_door && v <= 350) begin
            return color_cyan;
        end
        if (h >= ps && h <= ps + 50 && v >= 351 && v <= 550) begin
            return color_blue;
        end
        if (h >= 250 && h <= 750 && v >= 200 && v <= 350) begin
            return color_white;
        end
        return color_red;
    endfunction

    ////////////////////
    // one frame of player and level rules
    task automatic model_tick(input bit u, input bit l, input bit r);
        bit slow;
        bit resp;
        int old_x;
        int nx;
        int ny;
        int ns;
        bit na;
        m_ticks++;
        slow  = (m_ticks % 3 == 0);
        old_x = m_x;
        resp  = (m_level == 0)
             || (m_door == int'(door_full) && m_timer + 1 == int'(blackout_ticks));
        nx = m_x;
        ny = m_y;
        ns = m_speed;
        na = m_air;
        if (resp) begin
            nx = int'(spawn_x);
            ny = int'(floor_y);
            ns = 0;
            na = 1'b0;
        end else begin
            if (m_door == 0 && m_y <= int'(floor_y) && l != r) begin
                if (r && m_x < int'(x_max)) begin
                    nx = m_x + int'(step_x);
                end else if (l && m_x > int'(x_min)) begin
                    nx = m_x - int'(step_x);
                end
            end
            if (u && !m_air) begin
                ny = m_y - int'(jump_speed);
                ns = int'(jump_speed);
                na = 1'b1;
            end else if (m_air) begin
                ny = m_y - m_speed;
                if (slow && m_speed > int'(max_fall)) begin
                    ns = m_speed - 1;
                end
                if (ny >= int'(floor_y) && !in_pit_span(nx)) begin
                    ny = int'(floor_y);
                    ns = 0;
                    na = 1'b0;
                end
            end else if (in_pit_span(nx)) begin
                ns = 0;
                na = 1'b1;
            end
            if (ny >= int'(death_y)) begin
                nx     = int'(spawn_x);
                ny     = int'(floor_y);
                ns     = 0;
                na     = 1'b0;
                m_died = 1'b1;
            end
        end
        if (m_level == 0) begin
            m_level = 1;
        end else if (m_door == int'(door_full)) begin
            if (resp) begin
                m_level = (m_level == int'(level_last)) ? 0 : m_level + 1;
                m_door  = 0;
                m_timer = 0;
            end else begin
                m_timer++;
            end
        end else if (old_x > int'(door_trigger_x) && slow) begin
            m_door += int'(door_step);
        end
        m_x     = nx;
        m_y     = ny;
        m_speed = ns;
        m_air   = na;
    endtask

    ////////////////////
    task automatic run_tick(input bit u, input bit l, input bit r);
        @(posedge clk);
        up    <= u;
        left  <= l;
        right <= r;
        repeat (3) @(posedge clk);
        h_count <= frame_last_h;
        v_count <= frame_last_v;
        @(posedge clk);
        h_count <= '0;
        v_count <= '0;
        // tick is high, new state lands on this edge
        @(posedge clk);
        model_tick(u, l, r);
    endtask

    task automatic probe_pixel(input string label, input int h, input int v);
        @(posedge clk);
        h_count <= coord_w'(h);
        v_count <= coord_w'(v);
        @(posedge clk);
        chk_label     = $sformatf("%s at (%0d,%0d)", label, h, v);
        chk_is_level  = 1'b0;
        chk_exp_color = expected_color(h, v);
        chk_req++;
        @(negedge clk);
    endtask

    task automatic probe_level();
        @(posedge clk);
        chk_label     = "level";
        chk_is_level  = 1'b1;
        chk_exp_level = level_w'(m_level);
        chk_req++;
        @(negedge clk);
    endtask

    task automatic probe_box();
        probe_pixel("box left edge", m_x, m_y);
        probe_pixel("left of box", m_x - 1, m_y);
        probe_pixel("box right edge", m_x + int'(player_w) - 1, m_y - int'(player_h) + 1);
        probe_pixel("right of box", m_x + int'(player_w), m_y - int'(player_h) + 1);
    endtask

    task automatic compare_color(input string label, input logic [color_w-1:0] expected,
                                 input logic [color_w-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s %s: expected rgb %h, got %h", cur_test, label, expected, actual);
        end
    endtask

    task automatic compare_level(input string label, input logic [level_w-1:0] expected,
                                 input logic [level_w-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s %s: expected %0d, got %0d", cur_test, label, expected, actual);
        end
    endtask

    always @(negedge clk) begin
        if (chk_req != chk_done) begin
            if (chk_is_level) begin
                compare_level(chk_label, chk_exp_level, level);
            end else begin
                compare_color(chk_label, chk_exp_color, rgb);
            end
            chk_done = chk_req;
        end
    end

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = errors + faults;
    endtask

    task automatic end_test();
        int n;
        // last compare runs on the falling edge before this
        @(posedge clk);
        n = errors + faults - errors_at_start;
        tests_run++;
        if (n == 0) begin
            $display("test %0d %s: ok", tests_run, cur_test);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, cur_test, n);
        end
    endtask

    ////////////////////
    initial begin
        int n;
        int lv;
        int ps;
        bit b_left;
        bit b_right;
        bit jump;
        reset   = 1'b1;
        up      = 1'b0;
        left    = 1'b0;
        right   = 1'b0;
        h_count = '0;
        v_count = '0;
        lfsr    = 8'd15;
        m_x     = int'(spawn_x);
        m_y     = int'(floor_y);
        m_speed = 0;
        m_air   = 1'b0;
        m_level = 0;
        m_door  = 0;
        m_timer = 0;
        m_ticks = 0;
        m_died  = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        start_test("reset_start_screen");
        probe_level();
        probe_pixel("area", 400, 250);
        probe_pixel("outside", 100, 100);
        probe_pixel("pit", 520, 400);
        run_tick(1'b0, 1'b0, 1'b0);
        probe_level();
        probe_pixel("area", 400, 250);
        probe_pixel("outside", 100, 100);
        probe_pixel("pit", 520, 400);
        probe_pixel("player", 300, 350);
        end_test();

        start_test("random_walk");
        for (int i = 0; i < 40; i++) begin
            lfsr    = lfsr_step(lfsr);
            b_right = lfsr[0];
            lfsr    = lfsr_step(lfsr);
            b_left  = lfsr[0];
            run_tick(1'b0, b_left, b_right);
            probe_box();
        end
        // push against the left wall
        n = 0;
        while (m_x != int'(x_min) && n < 78) begin
            run_tick(1'b0, 1'b1, 1'b0);
            probe_box();
            n++;
        end
        run_tick(1'b0, 1'b1, 1'b0);
        probe_box();
        end_test();

        start_test("jump_arc");
        run_tick(1'b1, 1'b0, 1'b0);
        n = 0;
        while (m_air && n < 58) begin
            probe_pixel("box top", m_x, m_y - int'(player_h) + 1);
            probe_pixel("above box", m_x, m_y - int'(player_h));
            probe_level();
            run_tick(1'b0, 1'b0, 1'b0);
            n++;
        end
        if (m_air) begin
            faults++;
            $display("%s: the player never came back to the floor", cur_test);
        end
        probe_pixel("box top", m_x, m_y - int'(player_h) + 1);
        probe_pixel("feet", m_x, m_y);
        end_test();

        start_test("pit_fall");
        m_died = 1'b0;
        n      = 0;
        while (!m_died && n < 250) begin
            run_tick(1'b0, 1'b0, 1'b1);
            probe_box();
            n++;
        end
        if (!m_died) begin
            faults++;
            $display("%s: the player never fell to the death line", cur_test);
        end
        end_test();

        start_test("door_and_levels");
        for (lv = 1; lv <= 4; lv++) begin
            n = 0;
            while (m_level == lv && n < 320) begin
                // hop over the pit
                ps   = pit_start_of(m_level);
                jump = !m_air && m_x >= ps - 14 && m_x < ps - 5;
                run_tick(jump, 1'b0, 1'b1);
                probe_pixel("door top", 690, 300 + m_door);
                probe_pixel("above door", 690, 299 + m_door);
                probe_level();
                n++;
            end
            if (m_level == lv) begin
                faults++;
                $display("%s: level %0d never advanced", cur_test, lv);
            end
        end
        probe_pixel("start screen", 400, 250);
        probe_level();
        end_test();

        $display("%0d tests, %0d check errors, %0d other failures", tests_run, errors, faults);
        if (errors == 0 && faults == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: filelist.f
rtl/game_pkg.sv
rtl/input_sync.sv
rtl/player_motion.sv
rtl/level_sequencer.sv
rtl/pixel_painter.sv
rtl/platform_game_top.sv
tests/platform_game_sva.sv
tests/platform_game_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= platform_game_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
